/* wb_accel_params.svh */
// Address map and CRC constants for the Wishbone stream accelerator
// Both registers sit in the user-project window starting at 0x3000_0000
`ifndef WB_ACCEL_PARAMS_SVH
`define WB_ACCEL_PARAMS_SVH

// ----------------------------------------------------------------------
// Bus address map
// ----------------------------------------------------------------------
`define WB_BASE_ADDR  32'h3000_0000
`define WB_ACCEL_ADDR (`WB_BASE_ADDR + 32'd4)

// ----------------------------------------------------------------------
// CRC-16 lane
// ----------------------------------------------------------------------
// CCITT polynomial, MSB-first, all-ones seed
`define CRC_POLY 16'h1021
`define CRC_SEED 16'hFFFF
`define CRC_BITS 32

`endif

/* wb_accel_pkg.sv */
// Shared types for the Wishbone stream accelerator
// Result word packs the CRC in bits 31:16 and the checksum in bits 15:0
package wb_accel_pkg;

  // Bus widths
  typedef logic [31:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // Lane result widths
  typedef logic [15:0] crc_t;
  typedef logic [15:0] csum_t;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2,
    LOOP = 2'd3
  } ctrl_state_e;

  // Joined result as returned on a read of the accelerator address
  typedef struct packed {
    crc_t  crc;
    csum_t csum;
  } accel_result_t;

endpackage

/* crc16_lane.sv */
// Bit-serial CRC-16 over one 32-bit word, MSB first
// done_o pulses CRC_BITS cycles after the start edge; crc_o holds until next start
`timescale 1ns/1ps
`include "wb_accel_params.svh"

module crc16_lane (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start_i,
  input  wb_accel_pkg::wb_data_t data_i,
  output logic                   done_o,
  output wb_accel_pkg::crc_t     crc_o
);

  localparam int CNT_W = $clog2(`CRC_BITS + 1);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`CRC_BITS - 1);

  logic                   busy_q;
  logic [CNT_W-1:0]       cnt_q;
  wb_accel_pkg::wb_data_t shift_q;
  wb_accel_pkg::crc_t     crc_q;

  // One step of the CRC update for a single input bit
  function automatic wb_accel_pkg::crc_t crc_step(input wb_accel_pkg::crc_t crc,
                                                  input logic bit_in);
    logic fb;
    fb = crc[15] ^ bit_in;
    return {crc[14:0], 1'b0} ^ (fb ? `CRC_POLY : 16'h0000);
  endfunction

  // Control state
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      done_o <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        // First bit is consumed at the load edge
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(1);
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == LAST_STEP) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (start_i) begin
      crc_q   <= crc_step(`CRC_SEED, data_i[31]);
      shift_q <= {data_i[30:0], 1'b0};
    end else if (busy_q) begin
      crc_q   <= crc_step(crc_q, shift_q[31]);
      shift_q <= {shift_q[30:0], 1'b0};
    end
  end

  assign crc_o = crc_q;

  // Controller must wait for the result before a new job
  no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
    busy_q |-> !start_i);

endmodule

/* csum_lane.sv */
// Ones'-complement checksum of the two halfwords of a word
// Result is the internet checksum; done_o pulses 2 cycles after start
`timescale 1ns/1ps

module csum_lane (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start_i,
  input  wb_accel_pkg::wb_data_t data_i,
  output logic                   done_o,
  output wb_accel_pkg::csum_t    csum_o
);

  logic                stage_q;
  logic [16:0]         sum_q;
  logic [15:0]         folded;
  wb_accel_pkg::csum_t csum_q;

  // Stage tracking and done pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      stage_q <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      stage_q <= start_i;
      done_o  <= stage_q;
    end
  end

  // Cycle one, raw 17-bit sum
  always_ff @(posedge clk) begin
    if (start_i) begin
      sum_q <= {1'b0, data_i[31:16]} + {1'b0, data_i[15:0]};
    end
  end

  // End-around carry, cannot overflow again
  assign folded = sum_q[15:0] + {15'd0, sum_q[16]};

  // Cycle two, fold and invert
  always_ff @(posedge clk) begin
    if (stage_q) begin
      csum_q <= ~folded;
    end
  end

  assign csum_o = csum_q;

endmodule

/* result_join.sv */
// Joins the CRC and checksum lane results into one stream word
// res_val_o is a level that stays up until res_rdy_i
`timescale 1ns/1ps

module result_join (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        crc_done_i,
  input  wb_accel_pkg::crc_t          crc_i,
  input  logic                        csum_done_i,
  input  wb_accel_pkg::csum_t         csum_i,
  input  logic                        res_rdy_i,
  output logic                        res_val_o,
  output wb_accel_pkg::accel_result_t res_o
);

  logic                        have_crc_q;
  logic                        have_csum_q;
  wb_accel_pkg::accel_result_t res_q;

  // ----------------------------------------------------------------------
  // Have flags
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      have_crc_q  <= 1'b0;
      have_csum_q <= 1'b0;
    end else if (res_rdy_i) begin
      have_crc_q  <= 1'b0;
      have_csum_q <= 1'b0;
    end else begin
      if (crc_done_i) begin
        have_crc_q <= 1'b1;
      end
      if (csum_done_i) begin
        have_csum_q <= 1'b1;
      end
    end
  end

  // Result capture, one field per lane
  always_ff @(posedge clk) begin
    if (crc_done_i) begin
      res_q.crc <= crc_i;
    end
    if (csum_done_i) begin
      res_q.csum <= csum_i;
    end
  end

  assign res_val_o = have_crc_q && have_csum_q;
  assign res_o     = res_q;

  // Held result must not move until it is taken
  res_stable: assert property (@(posedge clk) disable iff (reset)
    (res_val_o && !res_rdy_i) |=> (res_val_o && $stable(res_o)));

endmodule

/* wb_accel_ctrl.sv */
// Wishbone slave for the loopback register and the accelerator job
// Byte selects are ignored; accesses that do not fit the state get no ack
// Only one job in flight and its result must be read before the next start
`timescale 1ns/1ps
`include "wb_accel_params.svh"

module wb_accel_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  // Wishbone slave side
  input  logic                        wbs_stb_i,
  input  logic                        wbs_cyc_i,
  input  logic                        wbs_we_i,
  input  wb_accel_pkg::wb_addr_t      wbs_adr_i,
  input  wb_accel_pkg::wb_data_t      wbs_dat_i,
  output logic                        wbs_ack_o,
  output wb_accel_pkg::wb_data_t      wbs_dat_o,
  // Stream side towards the lanes and the join stage
  output logic                        start_o,
  output wb_accel_pkg::wb_data_t      job_data_o,
  input  logic                        res_val_i,
  input  wb_accel_pkg::accel_result_t res_i,
  output logic                        res_rdy_o
);

  wb_accel_pkg::ctrl_state_e state, next_state;

  logic                   bus_req;
  logic                   is_loop_wr;
  logic                   is_loop_rd;
  logic                   is_accel_wr;
  logic                   is_accel_rd;
  logic                   loop_en;
  logic                   dat_sel;
  wb_accel_pkg::wb_data_t loop_q;

  // ----------------------------------------------------------------------
  // Address and cycle decode
  // ----------------------------------------------------------------------
  always_comb begin
    bus_req     = wbs_stb_i && wbs_cyc_i;
    is_loop_wr  = bus_req && wbs_we_i && (wbs_adr_i == `WB_BASE_ADDR);
    is_loop_rd  = bus_req && !wbs_we_i && (wbs_adr_i == `WB_BASE_ADDR);
    is_accel_wr = bus_req && wbs_we_i && (wbs_adr_i == `WB_ACCEL_ADDR);
    is_accel_rd = bus_req && !wbs_we_i && (wbs_adr_i == `WB_ACCEL_ADDR);
  end

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wb_accel_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      wb_accel_pkg::IDLE: begin
        if (is_accel_wr) begin
          next_state = wb_accel_pkg::BUSY;
        end else if (is_loop_wr) begin
          next_state = wb_accel_pkg::LOOP;
        end
      end
      // Write is still held by the host until the result shows up
      wb_accel_pkg::BUSY: begin
        if (res_val_i && is_accel_wr) begin
          next_state = wb_accel_pkg::DONE;
        end
      end
      wb_accel_pkg::DONE: begin
        if (is_accel_rd) begin
          next_state = wb_accel_pkg::IDLE;
        end
      end
      wb_accel_pkg::LOOP: begin
        if (is_loop_rd) begin
          next_state = wb_accel_pkg::IDLE;
        end
      end
      default: next_state = wb_accel_pkg::IDLE;
    endcase
  end

  // Outputs are combinational from state and decode
  always_comb begin
    wbs_ack_o = 1'b0;
    start_o   = 1'b0;
    res_rdy_o = 1'b0;
    loop_en   = 1'b0;
    dat_sel   = 1'b0;
    case (state)
      wb_accel_pkg::IDLE: begin
        if (is_accel_wr) begin
          start_o = 1'b1;
        end else if (is_loop_wr) begin
          wbs_ack_o = 1'b1;
          loop_en   = 1'b1;
        end
      end
      wb_accel_pkg::BUSY: begin
        wbs_ack_o = res_val_i && is_accel_wr;
      end
      wb_accel_pkg::DONE: begin
        if (is_accel_rd) begin
          wbs_ack_o = 1'b1;
          res_rdy_o = 1'b1;
          dat_sel   = 1'b1;
        end
      end
      wb_accel_pkg::LOOP: begin
        wbs_ack_o = is_loop_rd;
      end
      default: wbs_ack_o = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Loopback register and read data
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      loop_q <= '0;
    end else if (loop_en) begin
      loop_q <= wbs_dat_i;
    end
  end

  // Job word goes straight from the bus to both lanes
  assign job_data_o = wbs_dat_i;
  assign wbs_dat_o  = dat_sel ? wb_accel_pkg::wb_data_t'(res_i) : loop_q;

  // Ack only ever answers a live bus request
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    wbs_ack_o |-> (wbs_stb_i && wbs_cyc_i));

  // A job starts only from IDLE with the join stage empty
  start_from_idle: assert property (@(posedge clk) disable iff (reset)
    start_o |-> ((state == wb_accel_pkg::IDLE) && !res_val_i));

endmodule

/* wb_accel_top.sv */
// Top level of the Wishbone stream accelerator
// Bus signals pass to the controller; lanes and join sit behind it
`timescale 1ns/1ps

module wb_accel_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wbs_stb_i,
  input  logic                   wbs_cyc_i,
  input  logic                   wbs_we_i,
  input  wb_accel_pkg::wb_addr_t wbs_adr_i,
  input  wb_accel_pkg::wb_data_t wbs_dat_i,
  output logic                   wbs_ack_o,
  output wb_accel_pkg::wb_data_t wbs_dat_o
);

  logic                        start;
  wb_accel_pkg::wb_data_t      job_data;
  logic                        crc_done;
  wb_accel_pkg::crc_t          crc;
  logic                        csum_done;
  wb_accel_pkg::csum_t         csum;
  logic                        res_val;
  logic                        res_rdy;
  wb_accel_pkg::accel_result_t res;

  wb_accel_ctrl wb_accel_ctrl_inst (
    .clk        (clk),
    .reset      (reset),
    .wbs_stb_i  (wbs_stb_i),
    .wbs_cyc_i  (wbs_cyc_i),
    .wbs_we_i   (wbs_we_i),
    .wbs_adr_i  (wbs_adr_i),
    .wbs_dat_i  (wbs_dat_i),
    .wbs_ack_o  (wbs_ack_o),
    .wbs_dat_o  (wbs_dat_o),
    .start_o    (start),
    .job_data_o (job_data),
    .res_val_i  (res_val),
    .res_i      (res),
    .res_rdy_o  (res_rdy)
  );

  // Both lanes start on the same pulse
  crc16_lane crc16_lane_inst (
    .clk     (clk),
    .reset   (reset),
    .start_i (start),
    .data_i  (job_data),
    .done_o  (crc_done),
    .crc_o   (crc)
  );

  csum_lane csum_lane_inst (
    .clk     (clk),
    .reset   (reset),
    .start_i (start),
    .data_i  (job_data),
    .done_o  (csum_done),
    .csum_o  (csum)
  );

  result_join result_join_inst (
    .clk         (clk),
    .reset       (reset),
    .crc_done_i  (crc_done),
    .crc_i       (crc),
    .csum_done_i (csum_done),
    .csum_i      (csum),
    .res_rdy_i   (res_rdy),
    .res_val_o   (res_val),
    .res_o       (res)
  );

endmodule

/* tb_wb_accel.sv */
// Table-driven testbench for the Wishbone stream accelerator
// Loop reads must follow a loop write; the table keeps loop accesses in pairs
`timescale 1ns/1ps
`include "wb_accel_params.svh"

module tb_wb_accel;

  localparam int RESET_CYCLES = 8;
  localparam int MAX_ROWS     = 16;
  localparam int OP_LOOP_WR   = 0;
  localparam int OP_LOOP_RD   = 1;
  localparam int OP_ACCEL     = 2;
  // Start edge, CRC_BITS cycles of CRC work, then one cycle in the join stage
  localparam int ACK_LATENCY  = `CRC_BITS + 1;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   wbs_stb_i;
  logic                   wbs_cyc_i;
  logic                   wbs_we_i;
  wb_accel_pkg::wb_addr_t wbs_adr_i;
  wb_accel_pkg::wb_data_t wbs_dat_i;
  logic                   wbs_ack_o;
  wb_accel_pkg::wb_data_t wbs_dat_o;

  // Stimulus table with expected values
  string                  name_tab [MAX_ROWS];
  int                     op_tab   [MAX_ROWS];
  wb_accel_pkg::wb_data_t dat_tab  [MAX_ROWS];
  int                     dly_tab  [MAX_ROWS];
  wb_accel_pkg::wb_data_t exp_tab  [MAX_ROWS];
  int                     n_rows = 0;
  wb_accel_pkg::wb_data_t last_loop = '0;
  logic [31:0]            rng_state = 32'h4d36;

  int errors = 0;
  int cycle_cnt = 0;
  int timeout_limit = MAX_ROWS * 40 + 100;

  wb_accel_top wb_accel_top_inst (
    .clk       (clk),
    .reset     (reset),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o)
  );

  always #2 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout after %0d cycles, the DUT never acknowledged an access", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Reference models
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // MSB-first CRC-16, input bit folded into the top of the register
  function automatic wb_accel_pkg::crc_t crc_model(input wb_accel_pkg::wb_data_t w);
    logic [15:0] crc;
    crc = `CRC_SEED;
    for (int i = `CRC_BITS - 1; i >= 0; i--) begin
      crc = crc ^ {w[i], 15'd0};
      if (crc[15]) begin
        crc = {crc[14:0], 1'b0} ^ `CRC_POLY;
      end else begin
        crc = {crc[14:0], 1'b0};
      end
    end
    return crc;
  endfunction

  // Internet checksum of the two halfwords
  function automatic wb_accel_pkg::csum_t csum_model(input wb_accel_pkg::wb_data_t w);
    logic [31:0] sum;
    sum = {16'd0, w[31:16]} + {16'd0, w[15:0]};
    while (sum[31:16] != 16'd0) begin
      sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    end
    return ~sum[15:0];
  endfunction

  task automatic add_row(input string name, input int op, input wb_accel_pkg::wb_data_t data,
                         input int dly);
    wb_accel_pkg::accel_result_t res;
    name_tab[n_rows] = name;
    op_tab[n_rows]   = op;
    dat_tab[n_rows]  = data;
    dly_tab[n_rows]  = dly;
    res.crc  = crc_model(data);
    res.csum = csum_model(data);
    if (op == OP_LOOP_WR) begin
      last_loop = data;
      exp_tab[n_rows] = data;
    end else if (op == OP_LOOP_RD) begin
      exp_tab[n_rows] = last_loop;
    end else begin
      exp_tab[n_rows] = res;
    end
    n_rows = n_rows + 1;
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic build_table();
    add_row("loop_wr_zero", OP_LOOP_WR, 32'h0000_0000, 0);
    add_row("loop_rd_zero", OP_LOOP_RD, 32'h0, 0);
    add_row("loop_wr_fixed", OP_LOOP_WR, 32'hdead_beef, 0);
    add_row("loop_rd_fixed", OP_LOOP_RD, 32'h0, 0);
    add_row("accel_fixed", OP_ACCEL, 32'h1234_5678, 0);
    add_row("accel_rand0", OP_ACCEL, next_rand(), 0);
    add_row("loop_wr_rand0", OP_LOOP_WR, next_rand(), 0);
    add_row("loop_rd_rand0", OP_LOOP_RD, 32'h0, 0);
    add_row("accel_rand1", OP_ACCEL, next_rand(), 0);
    add_row("loop_wr_rand1", OP_LOOP_WR, next_rand(), 0);
    add_row("loop_rd_rand1", OP_LOOP_RD, 32'h0, 0);
    add_row("accel_ones", OP_ACCEL, 32'hffff_ffff, 0);
    add_row("accel_delayed", OP_ACCEL, next_rand(), 7);
    timeout_limit = n_rows * 40 + 100;
  endtask

  // ----------------------------------------------------------------------
  // Bus access, starts 1 ns after an edge and ends 1 ns after an edge
  // ----------------------------------------------------------------------
  task automatic bus_access(input logic we, input wb_accel_pkg::wb_addr_t adr,
                            input wb_accel_pkg::wb_data_t wdat,
                            output wb_accel_pkg::wb_data_t rdat, output int waits);
    waits     = 0;
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_we_i  = we;
    wbs_adr_i = adr;
    wbs_dat_i = wdat;
    @(negedge clk);
    while (!wbs_ack_o) begin
      waits = waits + 1;
      @(negedge clk);
    end
    rdat = wbs_dat_o;
    @(posedge clk);
    #1;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic check_value(input string name, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else begin
      errors = errors + 1;
      $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic run_row(input int i);
    wb_accel_pkg::wb_data_t      rdat;
    wb_accel_pkg::accel_result_t exp_res;
    wb_accel_pkg::accel_result_t act_res;
    int                          waits;
    case (op_tab[i])
      OP_LOOP_WR: begin
        bus_access(1'b1, `WB_BASE_ADDR, dat_tab[i], rdat, waits);
        check_value(name_tab[i], "ack_wait", 32'd0, waits);
      end
      OP_LOOP_RD: begin
        bus_access(1'b0, `WB_BASE_ADDR, 32'h0, rdat, waits);
        check_value(name_tab[i], "ack_wait", 32'd0, waits);
        check_value(name_tab[i], "loop_data", exp_tab[i], rdat);
      end
      default: begin
        bus_access(1'b1, `WB_ACCEL_ADDR, dat_tab[i], rdat, waits);
        check_value(name_tab[i], "ack_latency", ACK_LATENCY, waits);
        if (dly_tab[i] > 0) begin
          repeat (dly_tab[i]) @(posedge clk);
          #1;
        end
        bus_access(1'b0, `WB_ACCEL_ADDR, 32'h0, rdat, waits);
        exp_res = exp_tab[i];
        act_res = rdat;
        check_value(name_tab[i], "read_wait", 32'd0, waits);
        check_value(name_tab[i], "crc", {16'd0, exp_res.crc}, {16'd0, act_res.crc});
        check_value(name_tab[i], "csum", {16'd0, exp_res.csum}, {16'd0, act_res.csum});
      end
    endcase
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    reset     = 1'b1;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    build_table();
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      assert (wbs_ack_o === 1'b0) else begin
        errors = errors + 1;
        $display("Ack was high during reset");
      end
    end
    reset = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    $display("Checks done over %0d rows, %0d errors", n_rows, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
wb_accel_pkg.sv
crc16_lane.sv
csum_lane.sv
result_join.sv
wb_accel_ctrl.sv
wb_accel_top.sv
tb_wb_accel.sv

/* Makefile */
TOP := tb_wb_accel

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
